// ==== compile.f ====
source/noc_pkg.sv
source/vc_fifo.sv
source/rr_arbiter.sv
source/input_port.sv
source/output_switch.sv
source/spidergon_node.sv
testbench/tb_clock.sv
testbench/spidergon_node_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module spidergon_node_tb \
	-f compile.f -o spidergon_node_tb &&
./obj_dir/spidergon_node_tb > sim.log 2>&1
cat sim.log 2>/dev/null
! grep -q "Testbench failed" sim.log && grep -q "Testbench passed" sim.log &&
echo "run passed" || { echo "run failed"; exit 1; }

// ==== source/input_port.sv ====
// input_port: ring input with two vc buffers, route latch per channel, release on tail
`timescale 1ns/1ps
`default_nettype none

module input_port import noc_pkg::*;
#(
	parameter node_t node_id = '0
)
(
	input logic clk,
	input logic reset,
	input flit_t in_flit,
	input logic in_valid,
	output logic [num_vcs-1:0] in_vc_ready,
	input logic [num_vcs-1:0] vc_pop,
	output logic [num_vcs-1:0] vc_req,
	output dir_t [num_vcs-1:0] vc_dir,
	output flit_t [num_vcs-1:0] vc_head_flit
);

	for (genvar v = 0; v < num_vcs; v++)
	begin : g_vc
		logic push;
		logic full;
		logic empty;
		flit_t head;
		kind_t kind;
		vc_state_t state;
		// route of the packet currently holding this channel
		dir_t route_q;
		// route of whatever head flit waits at the buffer head
		dir_t route_now;

		// the flit carries its own vc number, which picks the buffer
		assign push = in_valid && (flit_vc(in_flit) == vc_t'(v));

		vc_fifo u_fifo
		(
			.clk(clk),
			.reset(reset),
			.push(push),
			.push_flit(in_flit),
			.pop(vc_pop[v]),
			.head_flit(head),
			.full(full),
			.empty(empty)
		);

		assign kind = flit_kind(head);
		assign route_now = route_of(node_id, flit_dest(head));

		// on/off back-pressure straight from the registered full flag
		assign in_vc_ready[v] = !full;

		// any waiting flit is a request; body flits follow the latched route
		assign vc_req[v] = !empty;
		assign vc_dir[v] = (state == vc_idle) ? route_now : route_q;
		assign vc_head_flit[v] = head;

		// channel FSM
		// idle until a head flit leaves, active until its tail leaves
		// a single-flit header passes through without leaving idle
		always_ff @(posedge clk)
		begin
			if (reset)
				state <= vc_idle;
			else if (vc_pop[v])
			begin
				if (kind == kind_tail || kind == kind_header)
					state <= vc_idle;
				else if (kind == kind_head)
					state <= vc_active;
			end
		end

		// capture the route as the first flit leaves
		always_ff @(posedge clk)
		begin
			if (vc_pop[v] && state == vc_idle)
				route_q <= route_now;
		end
	end

endmodule

`default_nettype wire

// ==== source/noc_pkg.sv ====
// noc_pkg: network sizes, flit layout, flit kinds, directions, channel states, routing rule
`default_nettype none

package noc_pkg;

	// ring and buffer sizes
	localparam int num_nodes = 8;
	localparam int num_vcs = 2;
	localparam int num_ports = 3;
	// three ring outputs plus the local ejection port
	localparam int num_outputs = 4;
	localparam int num_chans = num_ports * num_vcs;
	localparam int vc_depth = 2;
	localparam int flit_w = 18;

	// flit layout, msb first
	// [17:16] kind, [15] vc, [14:12] destination, [11:9] source, rest payload
	// body and tail flits use bits 14..0 as payload
	typedef logic [flit_w-1:0] flit_t;
	typedef logic [$clog2(num_nodes)-1:0] node_t;
	typedef logic vc_t;

	typedef enum logic [1:0] {
		kind_tail = 2'b00,
		kind_head = 2'b01,
		kind_body = 2'b10,
		kind_header = 2'b11
	} kind_t;

	// port indices follow the same numbering
	typedef enum logic [1:0] {
		dir_anti = 2'd0,
		dir_clock = 2'd1,
		dir_across = 2'd2,
		dir_local = 2'd3
	} dir_t;

	typedef enum logic {
		vc_idle,
		vc_active
	} vc_state_t;

	// field extraction
	function automatic kind_t flit_kind(flit_t f);
		return kind_t'(f[flit_w-1 -: 2]);
	endfunction

	function automatic vc_t flit_vc(flit_t f);
		return f[flit_w-3];
	endfunction

	function automatic node_t flit_dest(flit_t f);
		return f[flit_w-4 -: $bits(node_t)];
	endfunction

	// shortest way round the ring, across for the far half
	function automatic dir_t route_of(node_t current, node_t dest);
		node_t r;
		dir_t d;
		// three-bit subtraction wraps modulo num_nodes
		r = dest - current;
		if (r == 0)
			d = dir_local;
		else if (r <= 2)
			d = dir_clock;
		else if (r >= node_t'(num_nodes - 2))
			d = dir_anti;
		else
			d = dir_across;
		return d;
	endfunction

endpackage

`default_nettype wire

// ==== source/output_switch.sv ====
// output_switch: packet lock per output, round-robin vc allocation, flit crossbar
`timescale 1ns/1ps
`default_nettype none

module output_switch import noc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [num_chans-1:0] vc_req,
	input dir_t [num_chans-1:0] vc_dir,
	input flit_t [num_chans-1:0] vc_head_flit,
	output logic [num_chans-1:0] vc_pop,
	output flit_t [num_ports-1:0] out_flit,
	output logic [num_ports-1:0] out_valid,
	input logic [num_ports-1:0][num_vcs-1:0] out_vc_ready,
	output flit_t local_flit,
	output logic local_valid,
	input logic local_ready
);

	// channels each output pops this cycle
	logic [num_chans-1:0] pop_o [num_outputs];
	// a channel popped by more than one output
	logic [num_chans-1:0] overlap;

	for (genvar o = 0; o < num_outputs; o++)
	begin : g_out
		logic [num_chans-1:0] req_o;
		logic [num_chans-1:0] grant;
		logic [num_chans-1:0] sel;
		logic [num_chans-1:0] owner;
		logic locked;
		logic ready_ok;
		logic move;
		flit_t flit;
		kind_t kind;

		// requesters routed to this output
		always_comb
		begin
			for (int c = 0; c < num_chans; c++)
				req_o[c] = vc_req[c] && (vc_dir[c] == dir_t'(o));
		end

		rr_arbiter #(.n(num_chans)) u_arb
		(
			.clk(clk),
			.reset(reset),
			.req(req_o),
			.advance(move && !locked),
			.grant(grant)
		);

		// the owner keeps the output until its tail, others wait
		assign sel = locked ? (owner & req_o) : grant;

		// and-or crossbar over the one-hot select
		always_comb
		begin
			flit = '0;
			for (int c = 0; c < num_chans; c++)
			begin
				if (sel[c])
					flit = flit | vc_head_flit[c];
			end
		end

		assign kind = flit_kind(flit);

		// downstream ready for the flit's own vc, or the single local ready
		if (o < num_ports)
		begin : g_ring
			assign ready_ok = out_vc_ready[o][flit_vc(flit)];
			assign out_flit[o] = flit;
			assign out_valid[o] = move;
		end
		else
		begin : g_local
			assign ready_ok = local_ready;
			assign local_flit = flit;
			assign local_valid = move;
		end

		// valid and pop rise together, transfer in the same cycle
		assign move = |sel && ready_ok;
		assign pop_o[o] = sel & {num_chans{move}};

		// lock on a head flit, release on tail; header never locks
		always_ff @(posedge clk)
		begin
			if (reset)
				locked <= 1'b0;
			else if (move)
			begin
				if (kind == kind_head)
					locked <= 1'b1;
				else if (kind == kind_tail || kind == kind_header)
					locked <= 1'b0;
			end
		end

		always_ff @(posedge clk)
		begin
			if (move && !locked)
				owner <= sel;
		end
	end

	// merge the per-output pops and note any channel taken twice
	always_comb
	begin
		vc_pop = '0;
		overlap = '0;
		for (int o = 0; o < num_outputs; o++)
		begin
			overlap = overlap | (vc_pop & pop_o[o]);
			vc_pop = vc_pop | pop_o[o];
		end
	end

	// each channel follows one route, so at most one output may drain it
	a_single_pop: assert property (@(posedge clk) disable iff (reset) overlap == '0);

endmodule

`default_nettype wire

// ==== source/rr_arbiter.sv ====
// rr_arbiter: round-robin arbiter, one-hot grant, rotating priority pointer
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter import noc_pkg::*;
#(
	parameter int n = num_chans
)
(
	input logic clk,
	input logic reset,
	input logic [n-1:0] req,
	input logic advance,
	output logic [n-1:0] grant
);

	// requester with the highest priority
	logic [$clog2(n)-1:0] ptr;
	logic [$clog2(n)-1:0] grant_idx;

	// first requester at or after ptr, searching upward with wrap
	always_comb
	begin
		logic found;
		int idx;
		found = 1'b0;
		grant = '0;
		grant_idx = ptr;
		for (int i = 0; i < n; i++)
		begin
			idx = (int'(ptr) + i) % n;
			if (!found && req[idx])
			begin
				found = 1'b1;
				grant[idx] = 1'b1;
				grant_idx = idx[$clog2(n)-1:0];
			end
		end
	end

	// winner drops to lowest priority once its grant is used
	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (advance && |grant)
			ptr <= (grant_idx == n - 1) ? '0 : grant_idx + 1'b1;
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant) && ((grant & ~req) == '0));

endmodule

`default_nettype wire

// ==== source/spidergon_node.sv ====
// spidergon_node: node top, three ring input ports feeding one output switch
`timescale 1ns/1ps
`default_nettype none

module spidergon_node import noc_pkg::*;
#(
	parameter node_t node_id = '0
)
(
	input logic clk,
	input logic reset,
	// ring inputs
	input flit_t in_flit_across,
	input logic in_valid_across,
	output logic [num_vcs-1:0] in_vc_ready_across,
	input flit_t in_flit_clockwise,
	input logic in_valid_clockwise,
	output logic [num_vcs-1:0] in_vc_ready_clockwise,
	input flit_t in_flit_anticlockwise,
	input logic in_valid_anticlockwise,
	output logic [num_vcs-1:0] in_vc_ready_anticlockwise,
	// ring outputs
	output flit_t out_flit_across,
	output logic out_valid_across,
	input logic [num_vcs-1:0] out_vc_ready_across,
	output flit_t out_flit_clockwise,
	output logic out_valid_clockwise,
	input logic [num_vcs-1:0] out_vc_ready_clockwise,
	output flit_t out_flit_anticlockwise,
	output logic out_valid_anticlockwise,
	input logic [num_vcs-1:0] out_vc_ready_anticlockwise,
	// ejection to the local core
	output flit_t local_flit,
	output logic local_valid,
	input logic local_ready
);

	// links gathered by port index, same numbering as dir_t
	flit_t [num_ports-1:0] in_flit;
	logic [num_ports-1:0] in_valid;
	logic [num_ports-1:0][num_vcs-1:0] in_ready;
	flit_t [num_ports-1:0] out_flit;
	logic [num_ports-1:0] out_valid;
	logic [num_ports-1:0][num_vcs-1:0] out_ready;

	// six channels, index port * num_vcs + vc
	logic [num_chans-1:0] vc_req;
	logic [num_chans-1:0] vc_pop;
	dir_t [num_chans-1:0] vc_dir;
	flit_t [num_chans-1:0] vc_head_flit;

	assign in_flit[dir_anti] = in_flit_anticlockwise;
	assign in_flit[dir_clock] = in_flit_clockwise;
	assign in_flit[dir_across] = in_flit_across;
	assign in_valid[dir_anti] = in_valid_anticlockwise;
	assign in_valid[dir_clock] = in_valid_clockwise;
	assign in_valid[dir_across] = in_valid_across;
	assign in_vc_ready_anticlockwise = in_ready[dir_anti];
	assign in_vc_ready_clockwise = in_ready[dir_clock];
	assign in_vc_ready_across = in_ready[dir_across];

	assign out_flit_anticlockwise = out_flit[dir_anti];
	assign out_flit_clockwise = out_flit[dir_clock];
	assign out_flit_across = out_flit[dir_across];
	assign out_valid_anticlockwise = out_valid[dir_anti];
	assign out_valid_clockwise = out_valid[dir_clock];
	assign out_valid_across = out_valid[dir_across];
	assign out_ready[dir_anti] = out_vc_ready_anticlockwise;
	assign out_ready[dir_clock] = out_vc_ready_clockwise;
	assign out_ready[dir_across] = out_vc_ready_across;

	for (genvar p = 0; p < num_ports; p++)
	begin : g_port
		input_port #(.node_id(node_id)) u_in
		(
			.clk(clk),
			.reset(reset),
			.in_flit(in_flit[p]),
			.in_valid(in_valid[p]),
			.in_vc_ready(in_ready[p]),
			.vc_pop(vc_pop[p*num_vcs +: num_vcs]),
			.vc_req(vc_req[p*num_vcs +: num_vcs]),
			.vc_dir(vc_dir[p*num_vcs +: num_vcs]),
			.vc_head_flit(vc_head_flit[p*num_vcs +: num_vcs])
		);
	end

	output_switch u_switch
	(
		.clk(clk),
		.reset(reset),
		.vc_req(vc_req),
		.vc_dir(vc_dir),
		.vc_head_flit(vc_head_flit),
		.vc_pop(vc_pop),
		.out_flit(out_flit),
		.out_valid(out_valid),
		.out_vc_ready(out_ready),
		.local_flit(local_flit),
		.local_valid(local_valid),
		.local_ready(local_ready)
	);

endmodule

`default_nettype wire

// ==== source/vc_fifo.sv ====
// vc_fifo: circular flit buffer for one virtual channel, registered full and empty
`timescale 1ns/1ps
`default_nettype none

module vc_fifo import noc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic push,
	input flit_t push_flit,
	input logic pop,
	output flit_t head_flit,
	output logic full,
	output logic empty
);

	flit_t mem [vc_depth];
	logic [$clog2(vc_depth)-1:0] wr_ptr;
	logic [$clog2(vc_depth)-1:0] rd_ptr;
	logic [$clog2(vc_depth+1)-1:0] count;
	logic [$clog2(vc_depth+1)-1:0] count_next;

	// pointer step with wrap at the buffer end
	function automatic logic [$clog2(vc_depth)-1:0] step(logic [$clog2(vc_depth)-1:0] p);
		return (p == vc_depth - 1) ? '0 : p + 1'b1;
	endfunction

	always_comb
	begin
		count_next = count;
		if (push && !pop)
			count_next = count + 1'b1;
		else if (pop && !push)
			count_next = count - 1'b1;
	end

	// storage, no reset needed
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end
		else
		begin
			if (push)
				wr_ptr <= step(wr_ptr);
			if (pop)
				rd_ptr <= step(rd_ptr);
			count <= count_next;
			// flags from the next count so they are valid right after the edge
			full <= (count_next == vc_depth);
			empty <= (count_next == 0);
		end
	end

	assign head_flit = mem[rd_ptr];

	// upstream honours the ready bit and the switch only pops a waiting flit
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		!(push && full) && !(pop && empty));

endmodule

`default_nettype wire

// ==== testbench/spidergon_node_tb.sv ====
// testbench top with random packets per input vc, channel scoreboard, wormhole and ready checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module spidergon_node_tb import noc_pkg::*;
();

	localparam int dut_node = 5;
	localparam int packets_per_port = 60;
	localparam int max_packet_len = 5;
	localparam int clk_period = 20;
	// twenty cycles for every flit of the longest possible run
	localparam int watchdog_ns = num_ports * packets_per_port * max_packet_len * 20 * clk_period;

	logic clk;
	logic reset;
	// link arrays indexed like dir_t
	flit_t in_flit [num_ports];
	logic in_valid [num_ports];
	logic [num_vcs-1:0] in_ready [num_ports];
	flit_t out_flit [num_ports];
	logic out_valid [num_ports];
	logic [num_vcs-1:0] out_ready [num_ports];
	flit_t local_flit;
	logic local_valid;
	logic local_ready;

	// per channel queues indexed by port * num_vcs + vc
	flit_t send_q [num_chans][$];
	flit_t exp_q [num_chans][$];
	int exp_dir_q [num_chans][$];
	int next_seq [num_chans];
	// flits held in each input buffer after the last rising edge
	int fifo_fill [num_chans];
	// channel holding each output or -1 when free
	int owner [num_outputs];
	// ready as seen at the last falling edge
	logic [num_vcs-1:0] ready_seen [num_ports];
	// vc written at the last rising edge whose full flag is not yet visible
	logic [num_vcs-1:0] sent_last [num_ports];
	logic traffic_on;
	int errors;
	int total_flits;
	int flits_seen;

	tb_clock #(.period(clk_period)) u_clk
	(
		.clk(clk)
	);

	spidergon_node #(.node_id(node_t'(dut_node))) dut
	(
		.clk(clk),
		.reset(reset),
		.in_flit_across(in_flit[dir_across]),
		.in_valid_across(in_valid[dir_across]),
		.in_vc_ready_across(in_ready[dir_across]),
		.in_flit_clockwise(in_flit[dir_clock]),
		.in_valid_clockwise(in_valid[dir_clock]),
		.in_vc_ready_clockwise(in_ready[dir_clock]),
		.in_flit_anticlockwise(in_flit[dir_anti]),
		.in_valid_anticlockwise(in_valid[dir_anti]),
		.in_vc_ready_anticlockwise(in_ready[dir_anti]),
		.out_flit_across(out_flit[dir_across]),
		.out_valid_across(out_valid[dir_across]),
		.out_vc_ready_across(out_ready[dir_across]),
		.out_flit_clockwise(out_flit[dir_clock]),
		.out_valid_clockwise(out_valid[dir_clock]),
		.out_vc_ready_clockwise(out_ready[dir_clock]),
		.out_flit_anticlockwise(out_flit[dir_anti]),
		.out_valid_anticlockwise(out_valid[dir_anti]),
		.out_vc_ready_anticlockwise(out_ready[dir_anti]),
		.local_flit(local_flit),
		.local_valid(local_valid),
		.local_ready(local_ready)
	);

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t %s: got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	// ring distance from this node picks the way out
	function automatic int expected_route(input int dest);
		int r;
		r = (dest - dut_node + num_nodes) % num_nodes;
		if (r == 0)
			return int'(dir_local);
		else if (r <= 2)
			return int'(dir_clock);
		else if (r >= num_nodes - 2)
			return int'(dir_anti);
		return int'(dir_across);
	endfunction

	// payload low bits carry input port and per-channel sequence number
	task automatic add_flit(input int p, input int v, input kind_t kind,
		input logic [5:0] upper, input int d);
		int c;
		flit_t f;
		c = p * num_vcs + v;
		f = {kind, v[0], upper, p[1:0], next_seq[c][6:0]};
		next_seq[c]++;
		send_q[c].push_back(f);
		exp_q[c].push_back(f);
		exp_dir_q[c].push_back(d);
		total_flits++;
	endtask

	task automatic build_packets();
		int v;
		int d;
		int nbody;
		logic [2:0] dest;
		logic [2:0] src;
		total_flits = 0;
		for (int p = 0; p < num_ports; p++)
		begin
			for (int k = 0; k < packets_per_port; k++)
			begin
				v = $urandom % num_vcs;
				dest = $urandom % num_nodes;
				src = $urandom % num_nodes;
				d = expected_route(dest);
				// one packet in four is a single-flit header
				if ($urandom % 4 == 0)
					add_flit(p, v, kind_header, {dest, src}, d);
				else
				begin
					nbody = $urandom % 4;
					add_flit(p, v, kind_head, {dest, src}, d);
					for (int b = 0; b < nbody; b++)
						add_flit(p, v, kind_body, $urandom, d);
					add_flit(p, v, kind_tail, $urandom, d);
				end
			end
		end
	endtask

	// scoreboard and wormhole tracking for one delivered flit
	task automatic check_output(input int o, input flit_t f, input logic rdy);
		int port;
		int c;
		int d;
		kind_t kind;
		flit_t exp_f;
		port = f[8:7];
		c = port * num_vcs + f[15];
		kind = kind_t'(f[17:16]);
		flits_seen++;
		check_value((o < num_ports) ? "out_vc_ready" : "local_ready", rdy, 1);
		if (port >= num_ports || exp_q[c].size() == 0)
		begin
			note_failure($sformatf("output %0d delivered flit %h that no input has outstanding",
				o, f));
			return;
		end
		// the flit leaves its buffer at the next rising edge
		fifo_fill[c]--;
		exp_f = exp_q[c].pop_front();
		d = exp_dir_q[c].pop_front();
		check_value("out_flit", f, exp_f);
		check_value("output index", o, d);
		// only the owning channel may pass between head and tail
		if (kind == kind_head || kind == kind_header)
		begin
			if (owner[o] != -1)
				note_failure($sformatf("output %0d began a packet of channel %0d inside channel %0d",
					o, c, owner[o]));
			owner[o] = (kind == kind_head) ? c : -1;
		end
		else
		begin
			if (owner[o] == -1)
				note_failure($sformatf("output %0d passed a body or tail flit with no open packet", o));
			else
				check_value("source channel", c, owner[o]);
			if (kind == kind_tail)
				owner[o] = -1;
		end
	endtask

	// one flit per port per cycle with the vc chosen among the eligible ones
	always @(posedge clk)
	begin
		logic ok0;
		logic ok1;
		int v;
		flit_t f;
		for (int p = 0; p < num_ports; p++)
		begin
			ok0 = traffic_on && send_q[p*num_vcs].size() > 0 && ready_seen[p][0]
				&& !sent_last[p][0];
			ok1 = traffic_on && send_q[p*num_vcs+1].size() > 0 && ready_seen[p][1]
				&& !sent_last[p][1];
			v = -1;
			if (ok0 && ok1)
				v = $urandom % 2;
			else if (ok0)
				v = 0;
			else if (ok1)
				v = 1;
			sent_last[p] = '0;
			if (v >= 0)
			begin
				f = send_q[p*num_vcs+v].pop_front();
				sent_last[p][v] = 1'b1;
				in_flit[p] <= f;
				in_valid[p] <= 1'b1;
			end
			else
				in_valid[p] <= 1'b0;
		end
	end

	// downstream readiness with each bit high seven times in ten
	always @(posedge clk)
	begin
		for (int p = 0; p < num_ports; p++)
		begin
			for (int v = 0; v < num_vcs; v++)
				out_ready[p][v] <= ($urandom % 100) < 70;
		end
		local_ready <= ($urandom % 100) < 70;
	end

	// outputs settle mid-cycle and the transfer happens at the next rising edge
	always @(negedge clk)
	begin
		for (int p = 0; p < num_ports; p++)
			ready_seen[p] = in_ready[p];
		if (!reset)
		begin
			// ready is the not-full flag of the flits written and drained up to the last edge
			for (int p = 0; p < num_ports; p++)
			begin
				for (int v = 0; v < num_vcs; v++)
					check_value("in_vc_ready", in_ready[p][v],
						fifo_fill[p*num_vcs+v] < vc_depth);
				if (in_valid[p])
					fifo_fill[p*num_vcs+in_flit[p][flit_w-3]]++;
			end
			for (int o = 0; o < num_ports; o++)
			begin
				if (out_valid[o])
					check_output(o, out_flit[o], out_ready[o][out_flit[o][flit_w-3]]);
			end
			if (local_valid)
				check_output(int'(dir_local), local_flit, local_ready);
		end
	end

	initial
	begin
		void'($urandom(19));
		reset <= 1'b1;
		traffic_on = 1'b0;
		errors = 0;
		flits_seen = 0;
		local_ready <= 1'b0;
		for (int p = 0; p < num_ports; p++)
		begin
			in_flit[p] <= '0;
			in_valid[p] <= 1'b0;
			out_ready[p] <= '0;
			ready_seen[p] = '0;
			sent_last[p] = '0;
		end
		for (int c = 0; c < num_chans; c++)
		begin
			next_seq[c] = 0;
			fifo_fill[c] = 0;
		end
		for (int o = 0; o < num_outputs; o++)
			owner[o] = -1;
		build_packets();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// idle state right after reset with nothing offered yet
		@(negedge clk);
		for (int p = 0; p < num_ports; p++)
		begin
			check_value("in_vc_ready", in_ready[p], 2'b11);
			check_value("out_valid", out_valid[p], 0);
		end
		check_value("local_valid", local_valid, 0);
		traffic_on = 1'b1;
		wait (flits_seen >= total_flits);
		// extra cycles so a duplicated flit still shows up
		repeat (10) @(negedge clk);
		for (int c = 0; c < num_chans; c++)
			check_value("flits left in model queue", exp_q[c].size(), 0);
		$display("errors: %0d, flits delivered: %0d of %0d", errors, flits_seen, total_flits);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// stalled traffic ends the run here
	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired with %0d of %0d flits delivered, errors: %0d",
			flits_seen, total_flits, errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// clock generator for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
	parameter int period = 20
)
(
	output logic clk
);

	// free-running, starts low
	initial
	begin
		clk = 1'b0;
		forever
			#(period / 2) clk = ~clk;
	end

endmodule

`default_nettype wire
